//--- all.f
+incdir+.
frodo_mem_pkg.sv
lane_bank_if.sv
bram_lane.sv
lane_bank.sv
write_mapper.sv
read_mapper.sv
frodo_main_mem.sv
frodo_mem_asserts.sv
tb_frodo_main_mem.sv

//--- bram_lane.sv
`timescale 1ns/1ps
`include "frodo_mem_params.svh"

module bram_lane (
  input logic clk,
  input logic i_wr_en,
  input frodo_mem_pkg::lane_mask_t i_wr_bytes,
  input frodo_mem_pkg::row_t i_wr_row,
  input frodo_mem_pkg::word_t i_wr_value,
  input logic i_rd_en,
  input frodo_mem_pkg::row_t i_rd_row,
  output frodo_mem_pkg::word_t o_rd_value
);
  import frodo_mem_pkg::*;

  word_t mem [`FM_DEPTH];
  word_t rd_q1;
  word_t rd_q2; // output register

  ////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      for (int b = 0; b < `FM_LANE_W / 8; b++) begin
        if (i_wr_bytes[b]) begin
          mem[i_wr_row][b*8 +: 8] <= i_wr_value[b*8 +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // read port, two register stages
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      rd_q1 <= mem[i_rd_row]; // old data on same-row write
    end
  end

  always_ff @(posedge clk) begin
    rd_q2 <= rd_q1;
  end

  assign o_rd_value = rd_q2;

endmodule

//--- frodo_main_mem.sv
`timescale 1ns/1ps

module frodo_main_mem (
  input logic clk,
  input logic i_rst,
  input frodo_mem_pkg::nblk_t i_num_blocks,

  // write port
  input frodo_mem_pkg::access_mode_t i_wr_mode,
  input frodo_mem_pkg::elem_idx_t i_wr_index,
  input frodo_mem_pkg::word_t i_wr_word,
  input frodo_mem_pkg::block_t i_wr_block,
  output frodo_mem_pkg::elem_idx_t o_wr_index_next,
  output logic o_wr_has_next,

  // read port
  input frodo_mem_pkg::access_mode_t i_rd_mode,
  input frodo_mem_pkg::elem_idx_t i_rd_index,
  output frodo_mem_pkg::elem_idx_t o_rd_index_next,
  output logic o_rd_has_next,
  output frodo_mem_pkg::word_t o_rd_word,
  output frodo_mem_pkg::block_t o_rd_block
);

  lane_bank_if wr_bus ();
  lane_bank_if rd_bus (); // wr_value unused here

  ////////////////////////////////////////////////////////////
  // input side
  ////////////////////////////////////////////////////////////

  write_mapper u_write_mapper (
    .i_mode       (i_wr_mode),
    .i_index      (i_wr_index),
    .i_num_blocks (i_num_blocks),
    .i_word       (i_wr_word),
    .i_block      (i_wr_block),
    .o_index_next (o_wr_index_next),
    .o_has_next   (o_wr_has_next),
    .bank         (wr_bus)
  );

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  lane_bank u_lane_bank (
    .clk     (clk),
    .i_rst   (i_rst),
    .wr_port (wr_bus),
    .rd_port (rd_bus)
  );

  ////////////////////////////////////////////////////////////
  // output side
  ////////////////////////////////////////////////////////////

  read_mapper u_read_mapper (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_mode       (i_rd_mode),
    .i_index      (i_rd_index),
    .i_num_blocks (i_num_blocks),
    .o_index_next (o_rd_index_next),
    .o_has_next   (o_rd_has_next),
    .o_word       (o_rd_word),
    .o_block      (o_rd_block),
    .bank         (rd_bus)
  );

endmodule

//--- frodo_mem_asserts.sv
`timescale 1ns/1ps

module frodo_mem_asserts (
  input logic clk,
  input logic i_rst,
  input frodo_mem_pkg::nblk_t i_num_blocks,
  input frodo_mem_pkg::access_mode_t i_wr_mode,
  input frodo_mem_pkg::elem_idx_t i_wr_index,
  input logic o_wr_has_next,
  input frodo_mem_pkg::access_mode_t i_rd_mode,
  input logic o_rd_has_next,
  input frodo_mem_pkg::word_t o_rd_word,
  input frodo_mem_pkg::block_t o_rd_block
);
  import frodo_mem_pkg::*;

  elem_idx_t wr_rule_next; // next write index by the address rules

  always_comb begin
    if (i_wr_mode == am_b_row && i_wr_index[8:0] + 9'd1 == i_num_blocks) begin
      wr_rule_next = (i_wr_index | 14'h1ff) + 1'b1; // first column of the next block row
    end else begin
      wr_rule_next = i_wr_index + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////

  idle_read_zero: assert property (@(posedge clk) disable iff (i_rst)
    (i_rd_mode == am_idle) |-> ##2 (o_rd_word == '0 && o_rd_block == '0))
    else $error("read outputs not zero two cycles after an idle read");

  idle_rd_no_next: assert property (@(posedge clk) disable iff (i_rst)
    (i_rd_mode == am_idle) |-> !o_rd_has_next)
    else $error("read has-next set while idle");

  ////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////

  idle_wr_no_next: assert property (@(posedge clk) disable iff (i_rst)
    (i_wr_mode == am_idle) |-> !o_wr_has_next)
    else $error("write has-next set while idle");

  // a continued walk never jumps past the stepped index
  wr_step_bound: assert property (@(posedge clk) disable iff (i_rst)
    (i_wr_mode != am_idle && o_wr_has_next) ##1 (i_wr_mode == $past(i_wr_mode))
      |-> (i_wr_index <= $past(wr_rule_next)))
    else $error("write index stepped past the next index");

endmodule

bind frodo_main_mem frodo_mem_asserts u_asserts (.*);

//--- frodo_mem_params.svh
`ifndef FRODO_MEM_PARAMS_SVH
`define FRODO_MEM_PARAMS_SVH

////////////////////////////////////////////////////////////
// bank geometry
////////////////////////////////////////////////////////////

`define FM_LANES 8
`define FM_LANE_W 64
`define FM_DEPTH 512
`define FM_ELEM_W 16

////////////////////////////////////////////////////////////
// region layout, base rows
////////////////////////////////////////////////////////////

`define FM_OFF_SSSTATE 0
`define FM_OFF_RNG 6
`define FM_OFF_SALT 7
`define FM_OFF_SEEDSE 8
`define FM_OFF_PKH 9
`define FM_OFF_K 11
`define FM_OFF_B 12

// last element index of the cell regions
`define FM_LAST_SSSTATE 24
`define FM_LAST_RNG 7
`define FM_LAST_SALT 7
`define FM_LAST_SEEDSE 7
`define FM_LAST_PKH 3
`define FM_LAST_K 3

`endif

//--- frodo_mem_pkg.sv
`include "frodo_mem_params.svh"

package frodo_mem_pkg;

  typedef logic [8:0] row_t;
  typedef logic [13:0] elem_idx_t;
  typedef logic [7:0] lane_mask_t;
  typedef logic [4*`FM_ELEM_W-1:0] word_t; // four elements
  typedef logic [`FM_LANES*`FM_LANE_W-1:0] block_t;
  typedef logic [8:0] nblk_t;

  typedef enum logic [3:0] {
    am_idle,
    am_ssstate,
    am_rng,
    am_salt,
    am_seedse,
    am_pkh,
    am_k,
    am_b_row, // one 1x4 row word per step
    am_b_mat  // one 8x4 block per step
  } access_mode_t;

  ////////////////////////////////////////////////////////////
  // region tables
  ////////////////////////////////////////////////////////////

  function automatic row_t region_base(access_mode_t mode);
    case (mode)
      am_ssstate: return row_t'(`FM_OFF_SSSTATE);
      am_rng: return row_t'(`FM_OFF_RNG);
      am_salt: return row_t'(`FM_OFF_SALT);
      am_seedse: return row_t'(`FM_OFF_SEEDSE);
      am_pkh: return row_t'(`FM_OFF_PKH);
      am_k: return row_t'(`FM_OFF_K);
      am_b_row, am_b_mat: return row_t'(`FM_OFF_B);
      default: return '0;
    endcase
  endfunction

  function automatic elem_idx_t cell_last(access_mode_t mode);
    case (mode)
      am_ssstate: return elem_idx_t'(`FM_LAST_SSSTATE);
      am_rng: return elem_idx_t'(`FM_LAST_RNG);
      am_salt: return elem_idx_t'(`FM_LAST_SALT);
      am_seedse: return elem_idx_t'(`FM_LAST_SEEDSE);
      am_pkh: return elem_idx_t'(`FM_LAST_PKH);
      am_k: return elem_idx_t'(`FM_LAST_K);
      default: return '0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // address mapping, shared by both ports
  ////////////////////////////////////////////////////////////

  function automatic row_t addr_row(access_mode_t mode, elem_idx_t index);
    row_t local_row;
    case (mode)
      am_idle: local_row = '0;
      am_b_row, am_b_mat: local_row = index[8:0]; // block column
      default: local_row = row_t'(index >> 3); // eight words per cell row
    endcase
    return region_base(mode) + local_row;
  endfunction

  function automatic lane_mask_t addr_lanes(access_mode_t mode, elem_idx_t index);
    case (mode)
      am_idle: return '0;
      am_b_mat: return '1;
      am_b_row: return lane_mask_t'(1) << index[11:9]; // row inside the block
      default: return lane_mask_t'(1) << index[2:0];
    endcase
  endfunction

  function automatic lane_mask_t addr_bytes(access_mode_t mode);
    return (mode == am_idle) ? '0 : '1;
  endfunction

  ////////////////////////////////////////////////////////////
  // index stepping
  ////////////////////////////////////////////////////////////

  function automatic elem_idx_t step_next(access_mode_t mode, elem_idx_t index,
                                          nblk_t num_blocks);
    nblk_t last_col;
    last_col = num_blocks - 1'b1;
    if (mode == am_b_row && index[8:0] == last_col) begin
      return {index[13:9] + 5'd1, 9'd0}; // wrap to next block row
    end
    return index + 1'b1;
  endfunction

  function automatic logic step_has_next(access_mode_t mode, elem_idx_t index,
                                         nblk_t num_blocks);
    nblk_t last_col;
    last_col = num_blocks - 1'b1;
    case (mode)
      am_idle: return 1'b0;
      am_b_row: return index != {5'd7, last_col};
      am_b_mat: return index != elem_idx_t'(last_col);
      default: return index != cell_last(mode);
    endcase
  endfunction

endpackage

//--- lane_bank.sv
`timescale 1ns/1ps
`include "frodo_mem_params.svh"

module lane_bank (
  input logic clk,
  input logic i_rst,
  lane_bank_if.bank wr_port,
  lane_bank_if.bank rd_port
);
  import frodo_mem_pkg::*;

  localparam int BYTES = `FM_LANE_W / 8;

  block_t raw_d2;
  block_t masked_d2;
  lane_mask_t rd_lane_d1;
  lane_mask_t rd_lane_d2;
  lane_mask_t rd_byte_d1;
  lane_mask_t rd_byte_d2;

  for (genvar l = 0; l < `FM_LANES; l++) begin : g_lane
    bram_lane u_lane (
      .clk        (clk),
      .i_wr_en    (wr_port.lane_en[l]),
      .i_wr_bytes (wr_port.byte_en),
      .i_wr_row   (wr_port.index),
      .i_wr_value (wr_port.wr_value[l*`FM_LANE_W +: `FM_LANE_W]),
      .i_rd_en    (rd_port.lane_en[l]),
      .i_rd_row   (rd_port.index),
      .o_rd_value (raw_d2[l*`FM_LANE_W +: `FM_LANE_W])
    );
  end

  ////////////////////////////////////////////////////////////
  // read masks follow the data through both stages
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_rst) begin
      rd_lane_d1 <= '0;
      rd_lane_d2 <= '0;
      rd_byte_d1 <= '0;
      rd_byte_d2 <= '0;
    end else begin
      rd_lane_d1 <= rd_port.lane_en;
      rd_lane_d2 <= rd_lane_d1;
      rd_byte_d1 <= rd_port.byte_en;
      rd_byte_d2 <= rd_byte_d1;
    end
  end

  always_comb begin
    masked_d2 = '0;
    for (int l = 0; l < `FM_LANES; l++) begin
      for (int b = 0; b < BYTES; b++) begin
        if (rd_lane_d2[l] && rd_byte_d2[b]) begin
          masked_d2[l*`FM_LANE_W + b*8 +: 8] = raw_d2[l*`FM_LANE_W + b*8 +: 8];
        end
      end
    end
  end

  assign rd_port.rd_value = masked_d2;

endmodule

//--- lane_bank_if.sv
`timescale 1ns/1ps

interface lane_bank_if;
  import frodo_mem_pkg::*;

  row_t index;
  lane_mask_t lane_en; // one bit per lane
  lane_mask_t byte_en; // byte mask inside each lane
  block_t wr_value;
  block_t rd_value; // masked, two cycles behind the request

  modport mapper (
    output index,
    output lane_en,
    output byte_en,
    output wr_value,
    input rd_value
  );

  modport bank (
    input index,
    input lane_en,
    input byte_en,
    input wr_value,
    output rd_value
  );

endinterface

//--- read_mapper.sv
`timescale 1ns/1ps
`include "frodo_mem_params.svh"

module read_mapper (
  input logic clk,
  input logic i_rst,
  input frodo_mem_pkg::access_mode_t i_mode,
  input frodo_mem_pkg::elem_idx_t i_index,
  input frodo_mem_pkg::nblk_t i_num_blocks,
  output frodo_mem_pkg::elem_idx_t o_index_next,
  output logic o_has_next,
  output frodo_mem_pkg::word_t o_word,
  output frodo_mem_pkg::block_t o_block,
  lane_bank_if.mapper bank
);
  import frodo_mem_pkg::*;

  word_t merged_d2;

  ////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////

  assign bank.index = addr_row(i_mode, i_index);
  assign bank.lane_en = addr_lanes(i_mode, i_index);
  assign bank.byte_en = addr_bytes(i_mode);

  assign o_index_next = step_next(i_mode, i_index, i_num_blocks);
  assign o_has_next = step_has_next(i_mode, i_index, i_num_blocks);

  ////////////////////////////////////////////////////////////
  // response side
  ////////////////////////////////////////////////////////////

  // disabled lanes come back as zero, so OR picks the live one
  always_comb begin
    merged_d2 = '0;
    for (int l = 0; l < `FM_LANES; l++) begin
      merged_d2 = merged_d2 | bank.rd_value[l*`FM_LANE_W +: `FM_LANE_W];
    end
  end

  assign o_word = merged_d2;
  assign o_block = bank.rd_value;

endmodule

//--- run.sh
#!/bin/sh
# Build and run the frodo main memory testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_frodo_main_mem \
  -Mdir obj_dir -o sim \
  -f all.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qxF '** PASS **' "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- tb_frodo_main_mem.sv
`timescale 1ns/1ps
`include "frodo_mem_params.svh"

module tb_frodo_main_mem;
  import frodo_mem_pkg::*;

  localparam int STEP_LIMIT = 600;

  logic clk;
  logic i_rst;
  nblk_t i_num_blocks;
  access_mode_t i_wr_mode;
  elem_idx_t i_wr_index;
  word_t i_wr_word;
  block_t i_wr_block;
  elem_idx_t o_wr_index_next;
  logic o_wr_has_next;
  access_mode_t i_rd_mode;
  elem_idx_t i_rd_index;
  elem_idx_t o_rd_index_next;
  logic o_rd_has_next;
  word_t o_rd_word;
  block_t o_rd_block;

  integer seed;
  word_t model [0:`FM_DEPTH-1][0:`FM_LANES-1]; // expected bank contents

  // pending read stream
  access_mode_t q_mode [$];
  elem_idx_t q_index [$];
  string q_name [$];

  frodo_main_mem i_dut (.*);

  always #50 clk = ~clk;

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  function automatic word_t random_word();
    return {$random(seed), $random(seed)};
  endfunction

  ////////////////////////////////////////////////////////////
  // layout of the stored objects
  ////////////////////////////////////////////////////////////

  function automatic int region_offset(access_mode_t mode);
    case (mode)
      am_ssstate: return `FM_OFF_SSSTATE;
      am_rng: return `FM_OFF_RNG;
      am_salt: return `FM_OFF_SALT;
      am_seedse: return `FM_OFF_SEEDSE;
      am_pkh: return `FM_OFF_PKH;
      am_k: return `FM_OFF_K;
      default: return `FM_OFF_B;
    endcase
  endfunction

  function automatic int region_last(access_mode_t mode);
    case (mode)
      am_ssstate: return `FM_LAST_SSSTATE;
      am_rng: return `FM_LAST_RNG;
      am_salt: return `FM_LAST_SALT;
      am_seedse: return `FM_LAST_SEEDSE;
      am_pkh: return `FM_LAST_PKH;
      default: return `FM_LAST_K;
    endcase
  endfunction

  function automatic int expected_row(access_mode_t mode, elem_idx_t idx);
    if (mode == am_b_row) return `FM_OFF_B + int'(idx[8:0]);
    if (mode == am_b_mat) return `FM_OFF_B + int'(idx);
    return region_offset(mode) + int'(idx) / 8;
  endfunction

  function automatic int expected_lane(access_mode_t mode, elem_idx_t idx);
    if (mode == am_b_row) return int'(idx[11:9]);
    return int'(idx) % 8;
  endfunction

  function automatic word_t expected_word(access_mode_t mode, elem_idx_t idx);
    word_t acc;
    acc = '0;
    if (mode == am_idle) return acc;
    if (mode == am_b_mat) begin
      for (int l = 0; l < `FM_LANES; l++) acc = acc | model[expected_row(mode, idx)][l];
      return acc; // all lanes ORed together
    end
    return model[expected_row(mode, idx)][expected_lane(mode, idx)];
  endfunction

  function automatic block_t expected_block(access_mode_t mode, elem_idx_t idx);
    block_t blk;
    int row;
    blk = '0;
    row = expected_row(mode, idx);
    if (mode == am_b_mat) begin
      for (int l = 0; l < `FM_LANES; l++) blk[l*64 +: 64] = model[row][l];
    end else if (mode != am_idle) begin
      blk[expected_lane(mode, idx)*64 +: 64] = model[row][expected_lane(mode, idx)];
    end
    return blk;
  endfunction

  function automatic elem_idx_t expected_next_index(access_mode_t mode, elem_idx_t idx);
    int col;
    int blk_row;
    col = int'(idx[8:0]);
    blk_row = int'(idx[13:9]);
    if (mode == am_b_row && col == int'(i_num_blocks) - 1) begin
      return elem_idx_t'((blk_row + 1) * 512); // column 0 of the next block row
    end
    return elem_idx_t'(int'(idx) + 1);
  endfunction

  function automatic logic expected_has_next(access_mode_t mode, elem_idx_t idx);
    case (mode)
      am_idle: return 1'b0;
      am_b_row: return !(int'(idx[13:9]) == 7 && int'(idx[8:0]) == int'(i_num_blocks) - 1);
      am_b_mat: return int'(idx) != int'(i_num_blocks) - 1;
      default: return int'(idx) != region_last(mode);
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // write and read sequences
  ////////////////////////////////////////////////////////////

  // follows o_wr_index_next until has-next falls
  task automatic write_region(input access_mode_t mode, output int steps);
    elem_idx_t idx;
    logic more;
    word_t w;
    block_t b;
    int row;
    idx = '0;
    steps = 0;
    do begin
      w = random_word();
      for (int l = 0; l < `FM_LANES; l++) b[l*64 +: 64] = random_word();
      @(posedge clk);
      i_wr_mode <= mode;
      i_wr_index <= idx;
      i_wr_word <= w;
      i_wr_block <= b;
      row = expected_row(mode, idx);
      if (mode == am_b_mat) begin
        for (int l = 0; l < `FM_LANES; l++) model[row][l] = b[l*64 +: 64];
      end else begin
        model[row][expected_lane(mode, idx)] = w;
      end
      @(negedge clk);
      more = o_wr_has_next;
      idx = o_wr_index_next;
      steps++;
      if (steps > STEP_LIMIT) stop_with_failure("write stepping never reached the last index");
    end while (more);
    @(posedge clk);
    i_wr_mode <= am_idle;
  endtask

  task automatic add_read(input access_mode_t mode, input elem_idx_t idx, input string name);
    q_mode.push_back(mode);
    q_index.push_back(idx);
    q_name.push_back(name);
  endtask

  // one request per cycle, each result checked two cycles later
  task automatic run_reads();
    word_t exp_w [$];
    block_t exp_b [$];
    int n;
    n = q_mode.size();
    for (int i = 0; i < n + 2; i++) begin
      @(posedge clk);
      if (i < n) begin
        i_rd_mode <= q_mode[i];
        i_rd_index <= q_index[i];
        exp_w.push_back(expected_word(q_mode[i], q_index[i]));
        exp_b.push_back(expected_block(q_mode[i], q_index[i]));
      end else begin
        i_rd_mode <= am_idle;
        i_rd_index <= '0;
      end
      @(negedge clk);
      if (i < n) begin
        assert (o_rd_has_next === expected_has_next(q_mode[i], q_index[i])) else
          stop_with_failure($sformatf("mismatch %s has_next expected %b actual %b",
                                      q_name[i], expected_has_next(q_mode[i], q_index[i]),
                                      o_rd_has_next));
        if (q_mode[i] != am_idle) begin
          assert (o_rd_index_next === expected_next_index(q_mode[i], q_index[i])) else
            stop_with_failure($sformatf("mismatch %s index_next expected %h actual %h",
                                        q_name[i], expected_next_index(q_mode[i], q_index[i]),
                                        o_rd_index_next));
        end
      end
      if (i >= 2) begin
        assert (o_rd_word === exp_w[i-2]) else
          stop_with_failure($sformatf("mismatch %s word expected %h actual %h",
                                      q_name[i-2], exp_w[i-2], o_rd_word));
        assert (o_rd_block === exp_b[i-2]) else
          stop_with_failure($sformatf("mismatch %s block expected %h actual %h",
                                      q_name[i-2], exp_b[i-2], o_rd_block));
      end
    end
    q_mode.delete();
    q_index.delete();
    q_name.delete();
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    access_mode_t cells [6];
    int steps;
    cells = '{am_ssstate, am_rng, am_salt, am_seedse, am_pkh, am_k};
    seed = 49;
    clk = 1'b0;
    i_rst = 1'b1;
    i_num_blocks = 9'd3;
    i_wr_mode = am_idle;
    i_wr_index = '0;
    i_wr_word = '0;
    i_wr_block = '0;
    i_rd_mode = am_idle;
    i_rd_index = '0;
    repeat (5) @(posedge clk);
    i_rst <= 1'b0;
    @(negedge clk);
    assert (o_rd_word == '0 && o_rd_block == '0) else
      stop_with_failure("read outputs are not zero after reset");

    // cell regions, written one after another, read back together
    foreach (cells[m]) begin
      write_region(cells[m], steps);
      assert (steps == region_last(cells[m]) + 1) else
        stop_with_failure($sformatf("mismatch cell_steps expected %0d actual %0d",
                                    region_last(cells[m]) + 1, steps));
    end
    foreach (cells[m]) begin
      for (int i = 0; i <= region_last(cells[m]); i++) add_read(cells[m], i, "cell_read");
    end
    run_reads();

    // B written by row, read by block
    write_region(am_b_row, steps);
    assert (steps == 24) else
      stop_with_failure($sformatf("mismatch b_row_steps expected 24 actual %0d", steps));
    for (int c = 0; c < 3; c++) add_read(am_b_mat, c, "b_row_then_block");
    run_reads();

    // B written by block, read by row
    write_region(am_b_mat, steps);
    assert (steps == 3) else
      stop_with_failure($sformatf("mismatch b_mat_steps expected 3 actual %0d", steps));
    for (int r = 0; r < 8; r++) begin
      for (int c = 0; c < 3; c++) add_read(am_b_row, {r[4:0], c[8:0]}, "b_block_then_row");
    end
    run_reads();

    // back to back with mixed modes and idle gaps
    for (int k = 0; k < 6; k++) begin
      add_read(am_b_mat, k % 3, "mixed_block");
      add_read(am_b_row, {k[4:0], 9'(k % 3)}, "mixed_row");
      add_read(am_ssstate, k, "mixed_cell");
      add_read(am_idle, '0, "mixed_idle");
    end
    run_reads();

    $display("** PASS **");
    $finish;
  end

  // watchdog over the whole run
  initial begin
    for (int c = 0; c < 20000; c++) @(posedge clk);
    stop_with_failure("simulation ran past its cycle limit");
  end

endmodule

//--- write_mapper.sv
`timescale 1ns/1ps
`include "frodo_mem_params.svh"

module write_mapper (
  input frodo_mem_pkg::access_mode_t i_mode,
  input frodo_mem_pkg::elem_idx_t i_index,
  input frodo_mem_pkg::nblk_t i_num_blocks,
  input frodo_mem_pkg::word_t i_word,
  input frodo_mem_pkg::block_t i_block,
  output frodo_mem_pkg::elem_idx_t o_index_next,
  output logic o_has_next,
  lane_bank_if.mapper bank
);
  import frodo_mem_pkg::*;

  logic wide_write;

  ////////////////////////////////////////////////////////////
  // bank controls
  ////////////////////////////////////////////////////////////

  assign bank.index = addr_row(i_mode, i_index);
  assign bank.lane_en = addr_lanes(i_mode, i_index); // idle writes nothing
  assign bank.byte_en = addr_bytes(i_mode);

  // word modes put the word on every lane, lane_en picks the target
  assign wide_write = (i_mode == am_b_mat);
  assign bank.wr_value = wide_write ? i_block : {`FM_LANES{i_word}};

  ////////////////////////////////////////////////////////////
  // index stepping
  ////////////////////////////////////////////////////////////

  assign o_index_next = step_next(i_mode, i_index, i_num_blocks);
  assign o_has_next = step_has_next(i_mode, i_index, i_num_blocks);

endmodule
